// File: src/l1_pf_pkg.sv
// Widths, state encoding and page translation structs for the prefetch entry
`default_nettype none

package l1_pf_pkg;

  // ==============================
  // Address geometry
  // ==============================
  localparam int unsigned ADDR_W     = 40;
  // 4 KB page
  localparam int unsigned PAGE_OFS_W = 12;
  localparam int unsigned PPN_W      = ADDR_W - PAGE_OFS_W;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [PPN_W-1:0]  ppn_t;

  // ==============================
  // Translation payloads
  // ==============================
  // Page from load pipeline or MMU
  typedef struct packed {
    ppn_t ppn;
    logic sec;
    logic share;
  } page_xlat_t;

  // MMU answer for this entry
  typedef struct packed {
    logic       vld;
    logic       err;
    page_xlat_t xlat;
  } ppn_rsp_t;

  // ==============================
  // Entry state machine
  // ==============================
  // Bit 2 set means the address may be compared
  typedef enum logic [2:0] {
    init_pf_addr = 3'b000,
    add_pf_va    = 3'b001,
    req_pf       = 3'b100,
    req_mmu      = 3'b101,
    wait_ppn     = 3'b110,
    dead         = 3'b111
  } l1_state_e;

endpackage

`default_nettype wire

// File: src/l1_pf_state_ctrl.sv
// Prefetch entry FSM with state strobes and BIU/MMU request-set decode
`timescale 1ns/1ps
`default_nettype none

module l1_pf_state_ctrl import l1_pf_pkg::*;
(
  input  wire       entry_clk,
  input  wire       cpurst_b,
  input  wire       pref_en,
  input  wire       mmu_dis,
  input  wire       tsm_is_judge,
  input  wire       pop_vld,
  input  wire       reinit_vld,
  input  wire       biu_grnt,
  input  wire       mmu_grnt,
  input  wire       biu_req_pending,
  input  wire       mmu_req_pending,
  input  wire       ppn_rsp_t ppn_rsp,
  input  wire       cross_4k,
  input  wire       in_region,
  output logic      init_vld,
  output logic      add_vld,
  output logic      ppn_up_vld,
  output logic      va_can_cmp,
  output logic      biu_req_set,
  output logic      mmu_req_set
);

  l1_state_e state;
  l1_state_e next_state;

  logic is_init;
  logic is_add;
  logic is_req_pf;
  logic is_req_mmu;
  logic is_wait_ppn;

  // ==============================
  // State register
  // ==============================
  // Pop, reinit or prefetch off force a fresh start
  always_ff @(posedge entry_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      state <= init_pf_addr;
    else if (pop_vld || reinit_vld || !pref_en)
      state <= init_pf_addr;
    else
      state <= next_state;
  end

  // ==============================
  // Next state
  // ==============================
  always_comb
  begin
    next_state = init_pf_addr;
    case (state)
      init_pf_addr:
        if (init_vld && pref_en)
          next_state = add_pf_va;
        else
          next_state = init_pf_addr;
      // One step of stride before the first request
      add_pf_va:
        next_state = req_pf;
      req_pf:
        if (add_vld && cross_4k && mmu_dis)
          next_state = dead;
        else if (add_vld && cross_4k)
          next_state = req_mmu;
        else
          next_state = req_pf;
      req_mmu:
        if (mmu_grnt)
          next_state = wait_ppn;
        else
          next_state = req_mmu;
      wait_ppn:
        if (ppn_rsp.vld && !ppn_rsp.err)
          next_state = req_pf;
        else if (ppn_rsp.vld && ppn_rsp.err)
          next_state = dead;
        else
          next_state = wait_ppn;
      // Left only by the forced return to init
      dead:
        next_state = dead;
      default:
        next_state = init_pf_addr;
    endcase
  end

  // ==============================
  // State decode
  // ==============================
  assign is_init     = (state == init_pf_addr);
  assign is_add      = (state == add_pf_va);
  assign is_req_pf   = (state == req_pf);
  assign is_req_mmu  = (state == req_mmu);
  assign is_wait_ppn = (state == wait_ppn);

  assign va_can_cmp  = state[2];

  // Strobes to the address and compare blocks
  assign init_vld    = is_init && tsm_is_judge;
  assign add_vld     = is_add || biu_grnt;
  assign ppn_up_vld  = is_wait_ppn && ppn_rsp.vld;

  // Request registers live outside, only set while not yet pending
  assign biu_req_set = is_req_pf && in_region && !biu_req_pending;
  assign mmu_req_set = is_req_mmu && !mmu_req_pending;

endmodule

`default_nettype wire

// File: src/l1_pf_addr_track.sv
// Prefetch VA register, page register, stride adder and 4 KB crossing test
`timescale 1ns/1ps
`default_nettype none

module l1_pf_addr_track import l1_pf_pkg::*;
(
  input  wire             entry_clk,
  input  wire             cpurst_b,
  input  wire             pref_en,
  input  wire             init_vld,
  input  wire             add_vld,
  input  wire             ppn_up_vld,
  input  wire addr_t      inst_new_va,
  input  wire addr_t      stride,
  input  wire page_xlat_t ld_xlat,
  input  wire ppn_rsp_t   ppn_rsp,
  output addr_t           pf_va,
  output ppn_t            vpn,
  output addr_t           pf_addr,
  output logic [1:0]      page_attr,
  output logic            cross_4k
);

  page_xlat_t               pf_page;
  addr_t                    pf_va_add_stride;
  logic [PAGE_OFS_W:0]      pf_va_sum_4k;

  // ==============================
  // Prefetch virtual address
  // ==============================
  always_ff @(posedge entry_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      pf_va <= '0;
    else if (init_vld)
      pf_va <= inst_new_va;
    else if (add_vld)
      pf_va <= pf_va_add_stride;
  end

  assign pf_va_add_stride = pf_va + stride;

  assign vpn = pf_va[ADDR_W-1:PAGE_OFS_W];

  // ==============================
  // Physical page and attributes
  // ==============================
  // Start page comes from the load pipeline, later pages from the MMU
  always_ff @(posedge entry_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      pf_page <= '0;
    else if (init_vld && pref_en)
      pf_page <= ld_xlat;
    else if (ppn_up_vld)
      pf_page <= ppn_rsp.xlat;
  end

  assign pf_addr   = {pf_page.ppn, pf_va[PAGE_OFS_W-1:0]};
  assign page_attr = {pf_page.sec, pf_page.share};

  // ==============================
  // Page crossing
  // ==============================
  // Carry out of the page offset
  assign pf_va_sum_4k = {1'b0, pf_va[PAGE_OFS_W-1:0]} + stride[PAGE_OFS_W:0];
  assign cross_4k     = pf_va_sum_4k[PAGE_OFS_W];

endmodule

`default_nettype wire

// File: src/l1_pf_region_cmp.sv
// Instruction address versus prefetch address compare and reinit request
`timescale 1ns/1ps
`default_nettype none

module l1_pf_region_cmp import l1_pf_pkg::*;
(
  input  wire        entry_clk,
  input  wire        cpurst_b,
  input  wire        create_dp_vld,
  input  wire        reinit_vld,
  input  wire        add_vld,
  input  wire        pf_inst_vld,
  input  wire        va_can_cmp,
  input  wire addr_t inst_new_va,
  input  wire addr_t pf_va,
  input  wire addr_t dist_stride,
  input  wire        stride_neg,
  output logic       cmp_va_vld,
  output addr_t      pf_va_sub_new_va,
  output logic       in_region,
  output logic       reinit_req
);

  addr_t diff_sub_dist;
  logic  pf_va_eq_new_va;
  logic  surpass;
  logic  surpass_set;
  logic  in_region_set;

  // ==============================
  // Compare pipeline strobe
  // ==============================
  always_ff @(posedge entry_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      cmp_va_vld <= 1'b0;
    else if (create_dp_vld || reinit_vld)
      cmp_va_vld <= 1'b0;
    else
      cmp_va_vld <= add_vld || (pf_inst_vld && va_can_cmp);
  end

  // ==============================
  // Distance arithmetic
  // ==============================
  assign pf_va_sub_new_va = pf_va - inst_new_va;
  assign diff_sub_dist    = pf_va_sub_new_va - dist_stride;
  assign pf_va_eq_new_va  = ~|pf_va_sub_new_va;

  // Signs flip meaning for a descending stream
  assign surpass_set   = (stride_neg ^ pf_va_sub_new_va[ADDR_W-1]) && !pf_va_eq_new_va;
  assign in_region_set = stride_neg ^ diff_sub_dist[ADDR_W-1];

  // ==============================
  // Compare flags
  // ==============================
  always_ff @(posedge entry_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      surpass   <= 1'b0;
      in_region <= 1'b1;
    end
    else if (create_dp_vld || reinit_vld)
    begin
      surpass   <= 1'b0;
      in_region <= 1'b1;
    end
    else if (cmp_va_vld && va_can_cmp)
    begin
      surpass   <= surpass_set;
      in_region <= in_region_set;
    end
  end

  // Instruction stream already past the prefetch point
  assign reinit_req = va_can_cmp && surpass;

endmodule

`default_nettype wire

// File: src/l1_pf_top.sv
// Prefetch entry level-one address machine top with FSM, address and compare blocks
`timescale 1ns/1ps
`default_nettype none

module l1_pf_top import l1_pf_pkg::*;
(
  input  wire             entry_clk,
  input  wire             cpurst_b,
  input  wire             pref_en,
  input  wire             mmu_dis,
  input  wire             tsm_is_judge,
  input  wire             pop_vld,
  input  wire             reinit_vld,
  input  wire             create_dp_vld,
  input  wire addr_t      inst_new_va,
  input  wire             pf_inst_vld,
  input  wire addr_t      stride,
  input  wire             stride_neg,
  input  wire addr_t      dist_stride,
  input  wire page_xlat_t ld_xlat,
  input  wire             biu_req_pending,
  input  wire             mmu_req_pending,
  input  wire             biu_grnt,
  input  wire             mmu_grnt,
  input  wire ppn_rsp_t   ppn_rsp,
  output logic            biu_req_set,
  output logic            mmu_req_set,
  output addr_t           pf_addr,
  output addr_t           pf_va,
  output ppn_t            vpn,
  output logic [1:0]      page_attr,
  output logic            cmp_va_vld,
  output logic            va_can_cmp,
  output addr_t           pf_va_sub_new_va,
  output logic            reinit_req
);

  // Strobes between blocks
  logic init_vld;
  logic add_vld;
  logic ppn_up_vld;
  logic cross_4k;
  logic in_region;

  // ==============================
  // Entry FSM
  // ==============================
  l1_pf_state_ctrl i_l1_pf_state_ctrl (
    .entry_clk       (entry_clk),
    .cpurst_b        (cpurst_b),
    .pref_en         (pref_en),
    .mmu_dis         (mmu_dis),
    .tsm_is_judge    (tsm_is_judge),
    .pop_vld         (pop_vld),
    .reinit_vld      (reinit_vld),
    .biu_grnt        (biu_grnt),
    .mmu_grnt        (mmu_grnt),
    .biu_req_pending (biu_req_pending),
    .mmu_req_pending (mmu_req_pending),
    .ppn_rsp         (ppn_rsp),
    .cross_4k        (cross_4k),
    .in_region       (in_region),
    .init_vld        (init_vld),
    .add_vld         (add_vld),
    .ppn_up_vld      (ppn_up_vld),
    .va_can_cmp      (va_can_cmp),
    .biu_req_set     (biu_req_set),
    .mmu_req_set     (mmu_req_set)
  );

  // ==============================
  // Address and page tracking
  // ==============================
  l1_pf_addr_track i_l1_pf_addr_track (
    .entry_clk   (entry_clk),
    .cpurst_b    (cpurst_b),
    .pref_en     (pref_en),
    .init_vld    (init_vld),
    .add_vld     (add_vld),
    .ppn_up_vld  (ppn_up_vld),
    .inst_new_va (inst_new_va),
    .stride      (stride),
    .ld_xlat     (ld_xlat),
    .ppn_rsp     (ppn_rsp),
    .pf_va       (pf_va),
    .vpn         (vpn),
    .pf_addr     (pf_addr),
    .page_attr   (page_attr),
    .cross_4k    (cross_4k)
  );

  // ==============================
  // Region compare
  // ==============================
  l1_pf_region_cmp i_l1_pf_region_cmp (
    .entry_clk        (entry_clk),
    .cpurst_b         (cpurst_b),
    .create_dp_vld    (create_dp_vld),
    .reinit_vld       (reinit_vld),
    .add_vld          (add_vld),
    .pf_inst_vld      (pf_inst_vld),
    .va_can_cmp       (va_can_cmp),
    .inst_new_va      (inst_new_va),
    .pf_va            (pf_va),
    .dist_stride      (dist_stride),
    .stride_neg       (stride_neg),
    .cmp_va_vld       (cmp_va_vld),
    .pf_va_sub_new_va (pf_va_sub_new_va),
    .in_region        (in_region),
    .reinit_req       (reinit_req)
  );

endmodule

`default_nettype wire

// File: tb/l1_pf_tb.sv
// Testbench for the prefetch entry address machine with reference model and assertions
`timescale 1ns/1ps
`default_nettype none

module l1_pf_tb import l1_pf_pkg::*;
();

  localparam int unsigned CLK_NS      = 10;
  localparam int unsigned RST_CYCLES  = 8;
  localparam int unsigned WAIT_LIMIT  = 40;
  localparam int unsigned N_TESTS     = 6;
  localparam int unsigned TEST_CYCLES = 300;
  localparam int unsigned WATCHDOG_NS = (RST_CYCLES + N_TESTS * TEST_CYCLES) * CLK_NS + 2000;

  logic       entry_clk, cpurst_b, pref_en, mmu_dis, tsm_is_judge, pop_vld, reinit_vld;
  logic       create_dp_vld, pf_inst_vld, stride_neg, biu_req_pending, mmu_req_pending;
  logic       biu_grnt, mmu_grnt;
  addr_t      inst_new_va, stride, dist_stride;
  page_xlat_t ld_xlat;
  ppn_rsp_t   ppn_rsp;
  logic       biu_req_set, mmu_req_set, cmp_va_vld, va_can_cmp, reinit_req;
  addr_t      pf_addr, pf_va, pf_va_sub_new_va;
  ppn_t       vpn;
  logic [1:0] page_attr;

  // Reference model and expectation flags
  l1_state_e           m_state;
  addr_t               m_va;
  page_xlat_t          m_page;
  logic [PAGE_OFS_W:0] m_ofs_sum;
  logic                m_can_cmp;
  logic                want_biu, block_biu, want_reinit, chk_idle, reinit_allowed;
  addr_t               run_va, run_stride;
  int unsigned         err_cnt, test_cnt, fail_cnt, err_at_start;

  l1_pf_top i_l1_pf_top (.*);

  initial
  begin
    entry_clk = 1'b0;
    forever #(CLK_NS / 2) entry_clk = ~entry_clk;
  end

  // ==============================
  // Reference model
  // ==============================
  // Carry out of the page offset on a grant step
  assign m_ofs_sum = {1'b0, m_va[PAGE_OFS_W-1:0]} + stride[PAGE_OFS_W:0];

  // States past the first stride step
  assign m_can_cmp = m_state inside {req_pf, req_mmu, wait_ppn, dead};

  always @(posedge entry_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      m_state <= init_pf_addr;
      m_va    <= '0;
      m_page  <= '0;
    end
    else
    begin
      if (m_state == init_pf_addr && tsm_is_judge)
        m_va <= inst_new_va;
      else if (m_state == add_pf_va || biu_grnt)
        m_va <= m_va + stride;
      if (m_state == init_pf_addr && tsm_is_judge && pref_en)
        m_page <= ld_xlat;
      else if (m_state == wait_ppn && ppn_rsp.vld)
        m_page <= ppn_rsp.xlat;
      if (pop_vld || reinit_vld || !pref_en)
        m_state <= init_pf_addr;
      else
        case (m_state)
          init_pf_addr: if (tsm_is_judge) m_state <= add_pf_va;
          add_pf_va:    m_state <= req_pf;
          req_pf:       if (biu_grnt && m_ofs_sum[PAGE_OFS_W]) m_state <= mmu_dis ? dead : req_mmu;
          req_mmu:      if (mmu_grnt) m_state <= wait_ppn;
          wait_ppn:     if (ppn_rsp.vld) m_state <= ppn_rsp.err ? dead : req_pf;
          default:      m_state <= m_state;
        endcase
    end
  end

  // ==============================
  // Checks
  // ==============================
  task automatic word_mismatch(input string name, input addr_t exp_val, input addr_t got_val);
    err_cnt++;
    $display("ERR %0t %s exp %h got %h", $time, name, exp_val, got_val);
  endtask

  task automatic note_failure(input string msg);
    err_cnt++;
    $display("%0t %s", $time, msg);
  endtask

  a_pf_va: assert property (@(posedge entry_clk) disable iff (!cpurst_b) pf_va == m_va)
    else word_mismatch("pf_va", $sampled(m_va), $sampled(pf_va));
  a_vpn: assert property (@(posedge entry_clk) disable iff (!cpurst_b)
    vpn == m_va[ADDR_W-1:PAGE_OFS_W])
    else word_mismatch("vpn", addr_t'($sampled(m_va[ADDR_W-1:PAGE_OFS_W])), addr_t'($sampled(vpn)));
  a_pf_addr: assert property (@(posedge entry_clk) disable iff (!cpurst_b)
    pf_addr == {m_page.ppn, m_va[PAGE_OFS_W-1:0]})
    else word_mismatch("pf_addr", $sampled({m_page.ppn, m_va[PAGE_OFS_W-1:0]}), $sampled(pf_addr));
  a_page_attr: assert property (@(posedge entry_clk) disable iff (!cpurst_b)
    page_attr == {m_page.sec, m_page.share})
    else word_mismatch("page_attr", addr_t'($sampled({m_page.sec, m_page.share})),
                       addr_t'($sampled(page_attr)));
  // Distance from the instruction stream to the modelled prefetch address
  a_va_diff: assert property (@(posedge entry_clk) disable iff (!cpurst_b)
    pf_va_sub_new_va == addr_t'(m_va - inst_new_va))
    else word_mismatch("pf_va_sub_new_va", addr_t'($sampled(m_va - inst_new_va)),
                       $sampled(pf_va_sub_new_va));
  a_mmu_req: assert property (@(posedge entry_clk) disable iff (!cpurst_b)
    mmu_req_set == (m_state == req_mmu && !mmu_req_pending))
    else word_mismatch("mmu_req_set", addr_t'($sampled(m_state == req_mmu && !mmu_req_pending)),
                       addr_t'($sampled(mmu_req_set)));
  a_can_cmp: assert property (@(posedge entry_clk) disable iff (!cpurst_b)
    va_can_cmp == m_can_cmp)
    else word_mismatch("va_can_cmp", addr_t'($sampled(m_can_cmp)), addr_t'($sampled(va_can_cmp)));
  // BIU request only from req_pf, never under back-pressure or out of region
  a_biu_off: assert property (@(posedge entry_clk) disable iff (!cpurst_b)
    (m_state != req_pf || biu_req_pending || block_biu) |-> !biu_req_set)
    else word_mismatch("biu_req_set", addr_t'(0), addr_t'(1));
  a_biu_on: assert property (@(posedge entry_clk) disable iff (!cpurst_b) want_biu |-> biu_req_set)
    else word_mismatch("biu_req_set", addr_t'(1), addr_t'(0));
  a_reinit_on: assert property (@(posedge entry_clk) disable iff (!cpurst_b)
    want_reinit |-> reinit_req)
    else word_mismatch("reinit_req", addr_t'(1), addr_t'(0));
  // Instruction stream stays behind the prefetch address outside the ahead case
  a_reinit_off: assert property (@(posedge entry_clk) disable iff (!cpurst_b)
    !reinit_allowed |-> !reinit_req)
    else word_mismatch("reinit_req", addr_t'(0), addr_t'(1));
  a_idle: assert property (@(posedge entry_clk) disable iff (!cpurst_b)
    chk_idle |-> !(biu_req_set || mmu_req_set || cmp_va_vld || reinit_req || va_can_cmp))
    else word_mismatch("idle outputs", addr_t'(0), addr_t'($sampled({biu_req_set, mmu_req_set,
                       cmp_va_vld, reinit_req, va_can_cmp})));

  // ==============================
  // Stimulus tasks
  // ==============================
  task automatic tick(input int unsigned n);
    repeat (n) @(posedge entry_clk);
  endtask

  // Poll at the falling edge, return on a rising edge
  task automatic wait_request(input logic mmu_side);
    int unsigned n;
    n = 0;
    @(negedge entry_clk);
    while (!(mmu_side ? mmu_req_set : biu_req_set) && n < WAIT_LIMIT)
    begin
      @(negedge entry_clk);
      n++;
    end
    if (n >= WAIT_LIMIT)
      note_failure(mmu_side ? "mmu_req_set never rose" : "biu_req_set never rose");
    @(posedge entry_clk);
  endtask

  // Judge in init, then expect the BIU request two cycles later
  task automatic start_run(input int unsigned grants_to_cross);
    int unsigned s;
    int unsigned ofs;
    s = 64 * (1 + $urandom() % 7);
    if (grants_to_cross == 0)
      ofs = $urandom() % 1024;
    else
      ofs = 4096 - (grants_to_cross + 1) * s + ($urandom() % s);
    run_va = {8'($urandom()), $urandom()};
    run_va[PAGE_OFS_W-1:0] = 12'(ofs);
    run_stride = addr_t'(s);
    stride       <= run_stride;
    dist_stride  <= run_stride * 32;
    inst_new_va  <= run_va;
    ld_xlat      <= {ppn_t'($urandom()), 2'($urandom())};
    tsm_is_judge <= 1'b1;
    @(posedge entry_clk);
    tsm_is_judge <= 1'b0;
    @(posedge entry_clk);
    want_biu <= 1'b1;
    @(posedge entry_clk);
    want_biu <= 1'b0;
  endtask

  task automatic grant_biu();
    wait_request(1'b0);
    biu_grnt <= 1'b1;
    @(posedge entry_clk);
    biu_grnt <= 1'b0;
  endtask

  task automatic grant_mmu(input logic err);
    wait_request(1'b1);
    mmu_grnt <= 1'b1;
    @(posedge entry_clk);
    mmu_grnt <= 1'b0;
    tick(3);
    ppn_rsp <= {1'b1, err, ppn_t'($urandom()), 2'($urandom())};
    @(posedge entry_clk);
    ppn_rsp <= '0;
  endtask

  task automatic pulse_reinit();
    reinit_vld <= 1'b1;
    @(posedge entry_clk);
    reinit_vld <= 1'b0;
    @(posedge entry_clk);
  endtask

  task automatic close_test(input string name);
    test_cnt++;
    if (err_cnt > err_at_start)
    begin
      fail_cnt++;
      $display("test %0d %s: failed with %0d errors", test_cnt, name, err_cnt - err_at_start);
    end
    else
      $display("test %0d %s: passed", test_cnt, name);
    err_at_start = err_cnt;
  endtask

  // ==============================
  // Test sequence
  // ==============================
  initial
  begin
    void'($urandom(32'h6279a382));
    {err_cnt, test_cnt, fail_cnt, err_at_start} = '0;
    {want_biu, block_biu, want_reinit, chk_idle, reinit_allowed} = '0;
    {run_va, run_stride} = '0;
    cpurst_b = 1'b0;
    pref_en = 1'b1;
    {mmu_dis, tsm_is_judge, pop_vld, reinit_vld, create_dp_vld, pf_inst_vld} = '0;
    {stride_neg, biu_req_pending, mmu_req_pending, biu_grnt, mmu_grnt} = '0;
    {inst_new_va, stride, dist_stride} = '0;
    ld_xlat = '0;
    ppn_rsp = '0;
    tick(RST_CYCLES);
    cpurst_b <= 1'b1;
    chk_idle <= 1'b1;
    tick(4);
    chk_idle <= 1'b0;
    close_test("reset state");
    start_run(0);
    close_test("judge to first request");
    repeat (3) grant_biu();
    biu_req_pending <= 1'b1;
    tick(5);
    biu_req_pending <= 1'b0;
    grant_biu();
    close_test("stride steps and back-pressure");
    pulse_reinit();
    start_run(2);
    repeat (2) grant_biu();
    grant_mmu(1'b0);
    wait_request(1'b0);
    close_test("page crossing and MMU refill");
    pulse_reinit();
    mmu_dis <= 1'b1;
    start_run(1);
    grant_biu();
    tick(6);
    pulse_reinit();
    mmu_dis <= 1'b0;
    start_run(1);
    grant_biu();
    grant_mmu(1'b1);
    tick(6);
    pulse_reinit();
    start_run(0);
    close_test("dead state and restart");
    // Instruction stream ahead of the prefetch address
    pulse_reinit();
    start_run(0);
    inst_new_va <= run_va + run_stride * 3;
    pf_inst_vld <= 1'b1;
    reinit_allowed <= 1'b1;
    @(posedge entry_clk);
    pf_inst_vld <= 1'b0;
    @(posedge entry_clk);
    want_reinit <= 1'b1;
    @(posedge entry_clk);
    want_reinit <= 1'b0;
    // Instruction stream too far behind
    pulse_reinit();
    reinit_allowed <= 1'b0;
    start_run(0);
    inst_new_va <= run_va + run_stride - run_stride * 40;
    pf_inst_vld <= 1'b1;
    @(posedge entry_clk);
    pf_inst_vld <= 1'b0;
    @(posedge entry_clk);
    block_biu <= 1'b1;
    tick(4);
    block_biu <= 1'b0;
    close_test("instruction compare");
    tick(2);
    $display("Summary: %0d tests, %0d failed, %0d errors", test_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

  initial
  begin
    #(WATCHDOG_NS);
    $display("Watchdog expired before the tests finished");
    $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
src/l1_pf_pkg.sv
src/l1_pf_state_ctrl.sv
src/l1_pf_addr_track.sv
src/l1_pf_region_cmp.sv
src/l1_pf_top.sv
tb/l1_pf_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the prefetch entry testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module l1_pf_tb -f files.f -o l1_pf_sim
./obj_dir/l1_pf_sim > sim.log 2>&1 || true
cat sim.log
if grep -q "^Done: no errors$" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
